// File: src.f
hdl/cpu_pkg.sv
hdl/fetch.sv
hdl/decode.sv
hdl/hazard_unit.sv
hdl/execute.sv
hdl/memory.sv
hdl/proc.sv
tests/proc_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the pass message appears
cd "$(dirname "$0")" &&
verilator --binary --timing -f src.f --top-module proc_tb -o proc_sim &&
./obj_dir/proc_sim | tee /dev/stderr | grep -F -q '** PASS **' &&
echo "simulation passed" ||
{
   echo "simulation failed"
   exit 1
}

// File: tests/proc_tb.sv
module proc_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int num_progs  = 5;
   localparam int prog_words = 8;

   logic              clk;
   logic              rst_n;
   logic              boot_we;
   cpu_pkg::word_t    boot_addr;
   cpu_pkg::instr_t   boot_data;
   logic              wb_valid;
   cpu_pkg::reg_idx_t wb_reg;
   cpu_pkg::word_t    wb_data;
   logic              halted;
   logic              err;

   // Program table with NOP in the unused slots
   cpu_pkg::instr_t   prog [num_progs][prog_words];
   int                prog_len [num_progs];
   // Expected outcome per program, high for err and low for halt
   logic              prog_err [num_progs];
   int unsigned       lcg_state = 67;
   logic              table_ready = 1'b0;
   int                watchdog_cycles;

   // Expected trace from the reference model
   cpu_pkg::reg_idx_t exp_reg [$];
   cpu_pkg::word_t    exp_data [$];
   logic              exp_err;
   cpu_pkg::word_t    model_mem [cpu_pkg::word_t];

   proc i_dut (
      .clk, .rst_n, .boot_we, .boot_addr, .boot_data,
      .wb_valid, .wb_reg, .wb_data, .halted, .err
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic int unsigned lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state >> 16;
   endfunction

   function automatic cpu_pkg::instr_t enc_alu(cpu_pkg::alu_op_t f, cpu_pkg::reg_idx_t rd,
                                               cpu_pkg::reg_idx_t rs, cpu_pkg::reg_idx_t rt);
      return {cpu_pkg::op_alu, rs, rt, rd, f};
   endfunction

   // ADDI, LD and ST share the rs / rt-or-rd / imm5 layout
   function automatic cpu_pkg::instr_t enc_imm5(cpu_pkg::opcode_t op, cpu_pkg::reg_idx_t rs,
                                                cpu_pkg::reg_idx_t rt, logic [4:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic cpu_pkg::instr_t enc_imm8(cpu_pkg::opcode_t op, cpu_pkg::reg_idx_t r,
                                                logic [7:0] imm);
      return {op, r, imm};
   endfunction

   function automatic cpu_pkg::instr_t enc_j(logic [10:0] off);
      return {cpu_pkg::op_j, off};
   endfunction

   task automatic report_failure(string why);
      $display("%s", why);
      $display("** FAIL **");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_word(string name, cpu_pkg::word_t got, cpu_pkg::word_t expected);
      if (got !== expected) begin
         report_failure($sformatf("Mismatch %s: got %h expected %h", name, got, expected));
      end
   endtask

   task automatic check_reg(string name, cpu_pkg::reg_idx_t got, cpu_pkg::reg_idx_t expected);
      if (got !== expected) begin
         report_failure($sformatf("Mismatch %s: got %h expected %h", name, got, expected));
      end
   endtask

   task automatic check_flag(string name, logic got, logic expected);
      if (got !== expected) begin
         report_failure($sformatf("Mismatch %s: got %h expected %h", name, got, expected));
      end
   endtask

   task automatic build_table();
      int unsigned r;
      for (int p = 0; p < num_progs; p++) begin
         for (int i = 0; i < prog_words; i++) begin
            prog[p][i] = {cpu_pkg::op_nop, 11'd0};
         end
      end
      // Dependent ALU chain on random operands
      r = lcg_next();
      prog[0][0] = enc_imm8(cpu_pkg::op_lbi, 3'd1, r[7:0]);
      r = lcg_next();
      prog[0][1] = enc_imm8(cpu_pkg::op_lbi, 3'd2, r[7:0]);
      prog[0][2] = enc_alu(cpu_pkg::alu_add, 3'd3, 3'd1, 3'd2);
      prog[0][3] = enc_alu(cpu_pkg::alu_sub, 3'd4, 3'd3, 3'd1);
      prog[0][4] = enc_alu(cpu_pkg::alu_and, 3'd5, 3'd4, 3'd2);
      prog[0][5] = enc_alu(cpu_pkg::alu_xor, 3'd6, 3'd5, 3'd3);
      r = lcg_next();
      prog[0][6] = enc_imm5(cpu_pkg::op_addi, 3'd6, 3'd7, r[4:0]);
      prog[0][7] = {cpu_pkg::op_halt, 11'd0};
      prog_len[0] = 8;
      prog_err[0] = 1'b0;
      // Store then load back
      prog[1][0] = enc_imm8(cpu_pkg::op_lbi, 3'd1, 8'ha5);
      prog[1][1] = enc_imm8(cpu_pkg::op_lbi, 3'd2, 8'd4);
      prog[1][2] = enc_imm5(cpu_pkg::op_st, 3'd2, 3'd1, 5'd2);
      prog[1][3] = enc_imm5(cpu_pkg::op_ld, 3'd2, 3'd3, 5'd2);
      prog[1][4] = enc_imm5(cpu_pkg::op_addi, 3'd3, 3'd4, 5'h1f);
      prog[1][5] = {cpu_pkg::op_halt, 11'd0};
      prog_len[1] = 6;
      prog_err[1] = 1'b0;
      // J and taken BEQZ each skip one word before a BEQZ that falls through
      prog[2][0] = enc_j(11'd2);
      prog[2][1] = enc_imm8(cpu_pkg::op_lbi, 3'd2, 8'd5);
      prog[2][2] = enc_imm8(cpu_pkg::op_beqz, 3'd0, 8'd2);
      prog[2][3] = enc_imm8(cpu_pkg::op_lbi, 3'd4, 8'd9);
      prog[2][4] = enc_imm8(cpu_pkg::op_lbi, 3'd3, 8'd7);
      prog[2][5] = enc_imm8(cpu_pkg::op_beqz, 3'd3, 8'd2);
      prog[2][6] = enc_imm5(cpu_pkg::op_addi, 3'd3, 3'd5, 5'd1);
      prog[2][7] = {cpu_pkg::op_halt, 11'd0};
      prog_len[2] = 8;
      prog_err[2] = 1'b0;
      // Odd load address
      prog[3][0] = enc_imm8(cpu_pkg::op_lbi, 3'd1, 8'd3);
      prog[3][1] = enc_imm5(cpu_pkg::op_ld, 3'd1, 3'd2, 5'd0);
      prog[3][2] = enc_imm8(cpu_pkg::op_lbi, 3'd3, 8'd1);
      prog[3][3] = {cpu_pkg::op_halt, 11'd0};
      prog_len[3] = 4;
      prog_err[3] = 1'b1;
      // Undefined opcode 11111
      prog[4][0] = enc_imm8(cpu_pkg::op_lbi, 3'd1, 8'd1);
      prog[4][1] = 16'hf800;
      prog[4][2] = enc_imm8(cpu_pkg::op_lbi, 3'd2, 8'd2);
      prog[4][3] = {cpu_pkg::op_halt, 11'd0};
      prog_len[4] = 4;
      prog_err[4] = 1'b1;
   endtask

   task automatic run_model(int p);
      cpu_pkg::word_t    regs [8];
      cpu_pkg::word_t    pc;
      cpu_pkg::instr_t   ins;
      cpu_pkg::reg_idx_t rs;
      cpu_pkg::reg_idx_t rt;
      cpu_pkg::word_t    imm5;
      cpu_pkg::word_t    imm8;
      cpu_pkg::word_t    addr;
      cpu_pkg::word_t    wr_val;
      cpu_pkg::reg_idx_t wr_reg;
      logic              wr_en;
      logic              done;
      int                widx;
      int                steps;
      exp_reg.delete();
      exp_data.delete();
      exp_err = 1'b0;
      for (int i = 0; i < 8; i++) begin
         regs[i] = '0;
      end
      pc    = '0;
      done  = 1'b0;
      steps = 0;
      while (!done) begin
         if (steps == 64) begin
            report_failure("Reference model did not reach HALT");
         end
         steps++;
         widx = int'(pc >> 1);
         ins  = (widx < prog_words) ? prog[p][widx] : '0;
         pc   = pc + 16'd2;
         rs   = ins[10:8];
         rt   = ins[7:5];
         imm5 = {{11{ins[4]}}, ins[4:0]};
         imm8 = {{8{ins[7]}}, ins[7:0]};
         addr = regs[rs] + imm5;
         wr_en  = 1'b0;
         wr_reg = rt;
         wr_val = '0;
         case (cpu_pkg::opcode_t'(ins[15:11]))
            cpu_pkg::op_halt: done = 1'b1;
            cpu_pkg::op_nop: begin
            end
            cpu_pkg::op_j: pc = pc + {{5{ins[10]}}, ins[10:0]};
            cpu_pkg::op_beqz: begin
               if (regs[rs] == '0) begin
                  pc = pc + imm8;
               end
            end
            cpu_pkg::op_addi: begin
               wr_en  = 1'b1;
               wr_val = regs[rs] + imm5;
            end
            cpu_pkg::op_lbi: begin
               wr_en  = 1'b1;
               wr_reg = rs;
               wr_val = imm8;
            end
            cpu_pkg::op_st, cpu_pkg::op_ld: begin
               if (addr[0]) begin
                  exp_err = 1'b1;
                  done    = 1'b1;
               end else if (ins[11]) begin
                  wr_en  = 1'b1;
                  wr_val = model_mem[addr];
               end else begin
                  model_mem[addr] = regs[rt];
               end
            end
            cpu_pkg::op_alu: begin
               wr_en  = 1'b1;
               wr_reg = ins[4:2];
               case (ins[1:0])
                  2'b00:   wr_val = regs[rs] + regs[rt];
                  2'b01:   wr_val = regs[rs] - regs[rt];
                  2'b10:   wr_val = regs[rs] & regs[rt];
                  default: wr_val = regs[rs] ^ regs[rt];
               endcase
            end
            default: begin
               exp_err = 1'b1;
               done    = 1'b1;
            end
         endcase
         if (wr_en) begin
            regs[wr_reg] = wr_val;
            exp_reg.push_back(wr_reg);
            exp_data.push_back(wr_val);
         end
      end
   endtask

   task automatic run_program(int p);
      logic stopped;
      run_model(p);
      if (exp_err !== prog_err[p]) begin
         report_failure("Reference model outcome disagrees with the program table");
      end
      // Boot the program while reset is held
      for (int i = 0; i < prog_words; i++) begin
         @(posedge clk);
         rst_n     <= 1'b0;
         boot_we   <= 1'b1;
         boot_addr <= cpu_pkg::word_t'(i);
         boot_data <= prog[p][i];
         @(negedge clk);
         if (i > 0) begin
            check_flag("wb_valid", wb_valid, 1'b0);
            check_reg("wb_reg", wb_reg, '0);
            check_word("wb_data", wb_data, '0);
            check_flag("halted", halted, 1'b0);
            check_flag("err", err, 1'b0);
         end
      end
      @(posedge clk);
      rst_n   <= 1'b1;
      boot_we <= 1'b0;
      stopped = 1'b0;
      while (!stopped) begin
         @(negedge clk);
         if (wb_valid) begin
            if (exp_reg.size() == 0) begin
               report_failure("Writeback seen with no expected result left");
            end
            check_reg("wb_reg", wb_reg, exp_reg.pop_front());
            check_word("wb_data", wb_data, exp_data.pop_front());
         end
         stopped = halted || err;
      end
      if (exp_reg.size() != 0) begin
         report_failure("Machine stopped before all expected writebacks");
      end
      check_flag("halted", halted, !prog_err[p]);
      check_flag("err", err, prog_err[p]);
      // Stopped machine stays quiet
      repeat (20) begin
         @(negedge clk);
         check_flag("wb_valid", wb_valid, 1'b0);
         check_flag("halted", halted, !prog_err[p]);
         check_flag("err", err, prog_err[p]);
      end
   endtask

   initial begin
      wait (table_ready);
      repeat (watchdog_cycles) @(posedge clk);
      $display("Watchdog timed out after %0d cycles without finishing", watchdog_cycles);
      $display("** FAIL **");
      $fatal(1, "timeout");
   end

   initial begin
      int total;
      rst_n     <= 1'b0;
      boot_we   <= 1'b0;
      boot_addr <= '0;
      boot_data <= '0;
      build_table();
      total = 0;
      for (int p = 0; p < num_progs; p++) begin
         total += prog_len[p];
      end
      watchdog_cycles = total * 20 + num_progs * 8;
      table_ready = 1'b1;
      for (int p = 0; p < num_progs; p++) begin
         run_program(p);
      end
      $display("** PASS **");
      $finish;
   end

endmodule

// File: hdl/proc.sv
module proc #(
   parameter int imem_words = cpu_pkg::imem_words_default,
   parameter int dmem_words = cpu_pkg::dmem_words_default
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              boot_we,
   input  cpu_pkg::word_t    boot_addr,
   input  cpu_pkg::instr_t   boot_data,
   output logic              wb_valid,
   output cpu_pkg::reg_idx_t wb_reg,
   output cpu_pkg::word_t    wb_data,
   output logic              halted,
   output logic              err
);

   // Fetch / decode
   logic              if_valid;
   cpu_pkg::instr_t   if_instr;
   cpu_pkg::word_t    if_pc_next;
   logic              stall;
   logic              freeze;
   logic              redirect;
   cpu_pkg::word_t    redirect_pc;

   // Decode / execute
   logic              id_valid;
   cpu_pkg::opcode_t  id_op;
   cpu_pkg::alu_op_t  id_alu_op;
   cpu_pkg::word_t    id_rs_data;
   cpu_pkg::word_t    id_rt_data;
   cpu_pkg::word_t    id_imm;
   cpu_pkg::reg_idx_t id_dest;
   logic              id_writes;
   cpu_pkg::word_t    id_pc_next;
   logic              id_is_halt;
   logic              id_illegal;
   cpu_pkg::reg_idx_t rs_idx;
   cpu_pkg::reg_idx_t rt_idx;
   logic              rs_used;
   logic              rt_used;

   // Execute / memory
   logic              ex_valid;
   cpu_pkg::opcode_t  ex_op;
   cpu_pkg::word_t    ex_result;
   cpu_pkg::word_t    ex_store_data;
   cpu_pkg::reg_idx_t ex_dest;
   logic              ex_writes;
   logic              ex_is_halt;
   logic              ex_illegal;

   fetch #(.imem_words(imem_words)) i_fetch (
      .clk, .rst_n, .boot_we, .boot_addr, .boot_data, .stall, .freeze,
      .redirect, .redirect_pc, .if_valid, .if_instr, .if_pc_next
   );

   decode i_decode (
      .clk, .rst_n, .if_valid, .if_instr, .if_pc_next, .stall, .redirect,
      .wb_valid, .wb_reg, .wb_data, .id_valid, .id_op, .id_alu_op,
      .id_rs_data, .id_rt_data, .id_imm, .id_dest, .id_writes, .id_pc_next,
      .id_is_halt, .id_illegal, .rs_idx, .rt_idx, .rs_used, .rt_used
   );

   hazard_unit i_hazard_unit (
      .rs_idx, .rt_idx, .rs_used, .rt_used, .id_valid, .id_dest, .id_writes,
      .ex_valid, .ex_dest, .ex_writes, .stall
   );

   execute i_execute (
      .clk, .rst_n, .id_valid, .id_op, .id_alu_op, .id_rs_data, .id_rt_data,
      .id_imm, .id_dest, .id_writes, .id_pc_next, .id_is_halt, .id_illegal,
      .ex_valid, .ex_op, .ex_result, .ex_store_data, .ex_dest, .ex_writes,
      .ex_is_halt, .ex_illegal, .redirect, .redirect_pc
   );

   memory #(.dmem_words(dmem_words)) i_memory (
      .clk, .rst_n, .ex_valid, .ex_op, .ex_result, .ex_store_data, .ex_dest,
      .ex_writes, .ex_is_halt, .ex_illegal, .wb_valid, .wb_reg, .wb_data,
      .halted, .err, .freeze
   );

endmodule

// File: hdl/memory.sv
module memory #(
   parameter int dmem_words = cpu_pkg::dmem_words_default
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              ex_valid,
   input  cpu_pkg::opcode_t  ex_op,
   input  cpu_pkg::word_t    ex_result,
   input  cpu_pkg::word_t    ex_store_data,
   input  cpu_pkg::reg_idx_t ex_dest,
   input  logic              ex_writes,
   input  logic              ex_is_halt,
   input  logic              ex_illegal,
   output logic              wb_valid,
   output cpu_pkg::reg_idx_t wb_reg,
   output cpu_pkg::word_t    wb_data,
   output logic              halted,
   output logic              err,
   output logic              freeze
);

   localparam int dmem_aw = $clog2(dmem_words);

   cpu_pkg::word_t     dmem [dmem_words];
   logic [dmem_aw-1:0] idx;
   logic               active;
   logic               is_mem;
   logic               misaligned;
   logic               is_load;

   // Nothing retires once the machine has stopped
   assign freeze     = halted || err;
   assign active     = ex_valid && !freeze;
   assign is_load    = (ex_op == cpu_pkg::op_ld);
   assign is_mem     = is_load || (ex_op == cpu_pkg::op_st);
   assign misaligned = is_mem && ex_result[0];
   assign idx        = ex_result[dmem_aw:1];

   always_ff @(posedge clk) begin
      if (active && ex_op == cpu_pkg::op_st && !misaligned) begin
         dmem[idx] <= ex_store_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb_valid <= 1'b0;
         halted   <= 1'b0;
         err      <= 1'b0;
      end else begin
         wb_valid <= active && ex_writes && !misaligned && !ex_illegal;
         if (active && ex_is_halt) begin
            halted <= 1'b1;
         end
         if (active && (ex_illegal || misaligned)) begin
            err <= 1'b1;
         end
      end
   end

   // Writeback mux
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb_reg  <= '0;
         wb_data <= '0;
      end else begin
         wb_reg  <= ex_dest;
         wb_data <= is_load ? dmem[idx] : ex_result;
      end
   end

endmodule

// File: hdl/execute.sv
module execute (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              id_valid,
   input  cpu_pkg::opcode_t  id_op,
   input  cpu_pkg::alu_op_t  id_alu_op,
   input  cpu_pkg::word_t    id_rs_data,
   input  cpu_pkg::word_t    id_rt_data,
   input  cpu_pkg::word_t    id_imm,
   input  cpu_pkg::reg_idx_t id_dest,
   input  logic              id_writes,
   input  cpu_pkg::word_t    id_pc_next,
   input  logic              id_is_halt,
   input  logic              id_illegal,
   output logic              ex_valid,
   output cpu_pkg::opcode_t  ex_op,
   output cpu_pkg::word_t    ex_result,
   output cpu_pkg::word_t    ex_store_data,
   output cpu_pkg::reg_idx_t ex_dest,
   output logic              ex_writes,
   output logic              ex_is_halt,
   output logic              ex_illegal,
   output logic              redirect,
   output cpu_pkg::word_t    redirect_pc
);

   cpu_pkg::word_t operand_b;
   cpu_pkg::word_t alu_out;
   cpu_pkg::word_t result;
   logic           taken;

   // Only the register ALU op uses rt as its second operand
   assign operand_b = (id_op == cpu_pkg::op_alu) ? id_rt_data : id_imm;

   always_comb begin
      case (id_alu_op)
         cpu_pkg::alu_add: alu_out = id_rs_data + operand_b;
         cpu_pkg::alu_sub: alu_out = id_rs_data - operand_b;
         cpu_pkg::alu_and: alu_out = id_rs_data & operand_b;
         cpu_pkg::alu_xor: alu_out = id_rs_data ^ operand_b;
         default:          alu_out = id_rs_data + operand_b;
      endcase
   end

   // LBI loads the extended immediate as is
   assign result = (id_op == cpu_pkg::op_lbi) ? id_imm : alu_out;

   always_comb begin
      taken = 1'b0;
      if (id_op == cpu_pkg::op_j) begin
         taken = 1'b1;
      end else if (id_op == cpu_pkg::op_beqz) begin
         taken = (id_rs_data == '0);
      end
   end

   assign redirect    = id_valid && taken;
   assign redirect_pc = id_pc_next + id_imm;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ex_valid <= 1'b0;
      end else begin
         ex_valid <= id_valid;
      end
   end

   always_ff @(posedge clk) begin
      ex_op         <= id_op;
      ex_result     <= result;
      ex_store_data <= id_rt_data;
      ex_dest       <= id_dest;
      ex_writes     <= id_writes;
      ex_is_halt    <= id_is_halt;
      ex_illegal    <= id_illegal;
   end

endmodule

// File: hdl/hazard_unit.sv
module hazard_unit (
   input  cpu_pkg::reg_idx_t rs_idx,
   input  cpu_pkg::reg_idx_t rt_idx,
   input  logic              rs_used,
   input  logic              rt_used,
   input  logic              id_valid,
   input  cpu_pkg::reg_idx_t id_dest,
   input  logic              id_writes,
   input  logic              ex_valid,
   input  cpu_pkg::reg_idx_t ex_dest,
   input  logic              ex_writes,
   output logic              stall
);

   logic id_live;
   logic ex_live;
   logic rs_hit;
   logic rt_hit;

   // Writers still ahead of the memory/writeback register
   assign id_live = id_valid && id_writes;
   assign ex_live = ex_valid && ex_writes;

   assign rs_hit = rs_used &&
                   ((id_live && id_dest == rs_idx) || (ex_live && ex_dest == rs_idx));
   assign rt_hit = rt_used &&
                   ((id_live && id_dest == rt_idx) || (ex_live && ex_dest == rt_idx));

   // The writeback stage itself is covered by register file write-through
   assign stall = rs_hit || rt_hit;

endmodule

// File: hdl/decode.sv
module decode (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              if_valid,
   input  cpu_pkg::instr_t   if_instr,
   input  cpu_pkg::word_t    if_pc_next,
   input  logic              stall,
   input  logic              redirect,
   input  logic              wb_valid,
   input  cpu_pkg::reg_idx_t wb_reg,
   input  cpu_pkg::word_t    wb_data,
   output logic              id_valid,
   output cpu_pkg::opcode_t  id_op,
   output cpu_pkg::alu_op_t  id_alu_op,
   output cpu_pkg::word_t    id_rs_data,
   output cpu_pkg::word_t    id_rt_data,
   output cpu_pkg::word_t    id_imm,
   output cpu_pkg::reg_idx_t id_dest,
   output logic              id_writes,
   output cpu_pkg::word_t    id_pc_next,
   output logic              id_is_halt,
   output logic              id_illegal,
   output cpu_pkg::reg_idx_t rs_idx,
   output cpu_pkg::reg_idx_t rt_idx,
   output logic              rs_used,
   output logic              rt_used
);

   cpu_pkg::word_t    regs [8];
   cpu_pkg::opcode_t  op;
   cpu_pkg::alu_op_t  alu_op;
   cpu_pkg::word_t    imm;
   cpu_pkg::reg_idx_t dest;
   cpu_pkg::word_t    rs_data;
   cpu_pkg::word_t    rt_data;
   logic              writes;
   logic              is_halt;
   logic              illegal;
   logic              reads_rs;
   logic              reads_rt;

   assign op     = cpu_pkg::opcode_t'(if_instr[15:11]);
   assign rs_idx = if_instr[10:8];
   assign rt_idx = if_instr[7:5];

   always_comb begin
      alu_op   = cpu_pkg::alu_add;
      imm      = {{11{if_instr[4]}}, if_instr[4:0]};
      dest     = if_instr[7:5];
      writes   = 1'b0;
      is_halt  = 1'b0;
      illegal  = 1'b0;
      reads_rs = 1'b0;
      reads_rt = 1'b0;
      case (op)
         cpu_pkg::op_halt: is_halt = 1'b1;
         cpu_pkg::op_nop: begin
         end
         cpu_pkg::op_j: imm = {{5{if_instr[10]}}, if_instr[10:0]};
         cpu_pkg::op_addi, cpu_pkg::op_ld: begin
            reads_rs = 1'b1;
            writes   = 1'b1;
         end
         cpu_pkg::op_beqz: begin
            reads_rs = 1'b1;
            imm      = {{8{if_instr[7]}}, if_instr[7:0]};
         end
         // Store data comes from the rt field
         cpu_pkg::op_st: begin
            reads_rs = 1'b1;
            reads_rt = 1'b1;
         end
         cpu_pkg::op_lbi: begin
            imm    = {{8{if_instr[7]}}, if_instr[7:0]};
            dest   = if_instr[10:8];
            writes = 1'b1;
         end
         cpu_pkg::op_alu: begin
            alu_op   = cpu_pkg::alu_op_t'(if_instr[1:0]);
            dest     = if_instr[4:2];
            reads_rs = 1'b1;
            reads_rt = 1'b1;
            writes   = 1'b1;
         end
         default: illegal = 1'b1;
      endcase
   end

   assign rs_used = if_valid && reads_rs;
   assign rt_used = if_valid && reads_rt;

   // Same-cycle writeback bypasses the array
   assign rs_data = (wb_valid && wb_reg == rs_idx) ? wb_data : regs[rs_idx];
   assign rt_data = (wb_valid && wb_reg == rt_idx) ? wb_data : regs[rt_idx];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_valid) begin
         regs[wb_reg] <= wb_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         id_valid <= 1'b0;
      end else begin
         id_valid <= if_valid && !stall && !redirect;
      end
   end

   always_ff @(posedge clk) begin
      id_op      <= op;
      id_alu_op  <= alu_op;
      id_rs_data <= rs_data;
      id_rt_data <= rt_data;
      id_imm     <= imm;
      id_dest    <= dest;
      id_writes  <= writes;
      id_pc_next <= if_pc_next;
      id_is_halt <= is_halt;
      id_illegal <= illegal;
   end

endmodule

// File: hdl/fetch.sv
module fetch #(
   parameter int imem_words = cpu_pkg::imem_words_default
) (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            boot_we,
   input  cpu_pkg::word_t  boot_addr,
   input  cpu_pkg::instr_t boot_data,
   input  logic            stall,
   input  logic            freeze,
   input  logic            redirect,
   input  cpu_pkg::word_t  redirect_pc,
   output logic            if_valid,
   output cpu_pkg::instr_t if_instr,
   output cpu_pkg::word_t  if_pc_next
);

   localparam int imem_aw = $clog2(imem_words);

   cpu_pkg::instr_t     imem [imem_words];
   cpu_pkg::word_t      pc;
   cpu_pkg::word_t      pc_next;
   logic [imem_aw-1:0]  rd_idx;

   assign pc_next = pc + cpu_pkg::pc_step;
   // Byte PC, word-indexed memory
   assign rd_idx  = pc[imem_aw:1];

   // Program load only while the core is held in reset
   always_ff @(posedge clk) begin
      if (!rst_n && boot_we) begin
         imem[boot_addr[imem_aw-1:0]] <= boot_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc       <= '0;
         if_valid <= 1'b0;
      end else if (freeze) begin
         if_valid <= 1'b0;
      end else if (redirect) begin
         // Drop the wrong-path slot
         pc       <= redirect_pc;
         if_valid <= 1'b0;
      end else if (!stall) begin
         pc       <= pc_next;
         if_valid <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         if_instr   <= imem[rd_idx];
         if_pc_next <= pc_next;
      end
   end

endmodule

// File: hdl/cpu_pkg.sv
package cpu_pkg;

   typedef logic [15:0] word_t;
   typedef logic [15:0] instr_t;
   typedef logic [2:0]  reg_idx_t;

   // Primary opcode, instruction bits 15..11
   typedef enum logic [4:0] {
      op_halt = 5'b00000,
      op_nop  = 5'b00001,
      op_j    = 5'b00100,
      op_addi = 5'b01000,
      op_beqz = 5'b01100,
      op_st   = 5'b10000,
      op_ld   = 5'b10001,
      op_lbi  = 5'b11000,
      op_alu  = 5'b11011
   } opcode_t;

   // Register ALU function, instruction bits 1..0 of op_alu
   typedef enum logic [1:0] {
      alu_add = 2'b00,
      alu_sub = 2'b01,
      alu_and = 2'b10,
      alu_xor = 2'b11
   } alu_op_t;

   // Bytes per instruction
   localparam word_t pc_step = 16'd2;

   // Default memory depths in 16-bit words
   localparam int imem_words_default = 256;
   localparam int dmem_words_default = 256;

endpackage
